/* axiLiteRegs.sv */
`timescale 1ns/1ps
`default_nettype none

module axiLiteRegs import mempoolPkg::*; #(
  // Total size of the register file in bytes
  parameter int unsigned                  RegNumBytes = NumRegs * StrbWidth,
  // One bit per byte, set means software cannot write it
  parameter logic [RegNumBytes-1:0]       AxiReadOnly = '0,
  // Reset contents, byte by byte
  parameter logic [RegNumBytes-1:0][7:0]  RegRstVal   = '0
) (
  input  wire logic                          clk_i,
  input  wire logic                          rstN_i,
  input  wire axiLiteReq_t                   axiReq_i,
  output axiLiteResp_t                       axiResp_o,
  output logic [RegNumBytes-1:0][7:0]        regQ_o
);

  // Whole words in the register file
  localparam int unsigned NumWords    = RegNumBytes / StrbWidth;
  // Address bits that select a byte inside a word
  localparam int unsigned ByteOffBits = $clog2(StrbWidth);

  // Word index taken from a byte address
  typedef logic [AddrWidth-ByteOffBits-1:0] wordAddr_t;

  // Register storage
  logic [RegNumBytes-1:0][7:0] regQ;

  // Write channel
  wordAddr_t wrWordAddr;
  logic      wrAccept;
  logic      wrInRange;
  logic      wrRoHit;
  logic      wrOk;
  logic      bPending;
  axiResp_t  bRespQ;

  // Read channel
  wordAddr_t rdWordAddr;
  logic      rdAccept;
  logic      rdInRange;
  data_t     rdData;
  logic      rdPending;
  data_t     rDataQ;
  axiResp_t  rRespQ;

  // Drop the byte offset, only the word matters
  assign wrWordAddr = axiReq_i.awAddr[AddrWidth-1:ByteOffBits];
  assign rdWordAddr = axiReq_i.arAddr[AddrWidth-1:ByteOffBits];

  // Address and data are taken together, never while a B response waits
  assign wrAccept  = axiReq_i.awValid & axiReq_i.wValid & ~bPending;
  assign wrInRange = wrWordAddr < wordAddr_t'(NumWords);

  // Any strobed byte that is read-only spoils the whole write
  always_comb begin
    wrRoHit = 1'b0;
    for (int w = 0; w < NumWords; w++) begin
      if (wrWordAddr == wordAddr_t'(w)) begin
        wrRoHit = |(axiReq_i.wStrb & AxiReadOnly[w*StrbWidth +: StrbWidth]);
      end
    end
  end

  assign wrOk = wrAccept & wrInRange & ~wrRoHit;

  // Byte-enabled update of the addressed word
  always_ff @(posedge clk_i) begin
    if (!rstN_i) begin
      regQ <= RegRstVal;
    end else if (wrOk) begin
      for (int w = 0; w < NumWords; w++) begin
        for (int b = 0; b < StrbWidth; b++) begin
          if ((wrWordAddr == wordAddr_t'(w)) && axiReq_i.wStrb[b]) begin
            regQ[w*StrbWidth + b] <= axiReq_i.wData[8*b +: 8];
          end
        end
      end
    end
  end

  // B response pending until the master takes it
  always_ff @(posedge clk_i) begin
    if (!rstN_i) begin
      bPending <= 1'b0;
    end else if (wrAccept) begin
      bPending <= 1'b1;
    end else if (bPending && axiReq_i.bReady) begin
      bPending <= 1'b0;
    end
  end

  // Response code is captured once per write and held under back-pressure
  always_ff @(posedge clk_i) begin
    if (wrAccept) begin
      bRespQ <= wrOk ? RespOkay : RespSlvErr;
    end
  end

  // One read at a time
  assign rdAccept  = axiReq_i.arValid & ~rdPending;
  assign rdInRange = rdWordAddr < wordAddr_t'(NumWords);

  // Select the addressed word, zero when out of range
  always_comb begin
    rdData = '0;
    for (int w = 0; w < NumWords; w++) begin
      if (rdWordAddr == wordAddr_t'(w)) begin
        rdData = regQ[w*StrbWidth +: StrbWidth];
      end
    end
  end

  // R response pending until the master takes it
  always_ff @(posedge clk_i) begin
    if (!rstN_i) begin
      rdPending <= 1'b0;
    end else if (rdAccept) begin
      rdPending <= 1'b1;
    end else if (rdPending && axiReq_i.rReady) begin
      rdPending <= 1'b0;
    end
  end

  // Read payload, frozen while rValid waits for rReady
  always_ff @(posedge clk_i) begin
    if (rdAccept) begin
      rDataQ <= rdData;
      rRespQ <= rdInRange ? RespOkay : RespSlvErr;
    end
  end

  // Bus outputs
  assign axiResp_o.awReady = wrAccept;
  assign axiResp_o.wReady  = wrAccept;
  assign axiResp_o.bResp   = bRespQ;
  assign axiResp_o.bValid  = bPending;
  assign axiResp_o.arReady = rdAccept;
  assign axiResp_o.rData   = rDataQ;
  assign axiResp_o.rResp   = rRespQ;
  assign axiResp_o.rValid  = rdPending;

  // Register contents as plain levels
  assign regQ_o = regQ;

endmodule

`default_nettype wire

/* ctrlRegisters.sv */
`timescale 1ns/1ps
`default_nettype none

module ctrlRegisters import mempoolPkg::*; #(
  parameter data_t TcdmBaseAddr = '0,
  parameter data_t TcdmSize     = '0,
  parameter data_t NumCores     = '0
) (
  input  wire logic         clk_i,
  input  wire logic         rstN_i,
  input  wire axiLiteReq_t  axiReq_i,
  output axiLiteResp_t      axiResp_o,
  output data_t             tcdmStartAddr_o,
  output data_t             tcdmEndAddr_o,
  output data_t             numCores_o,
  output data_t             eoc_o
);

  localparam int unsigned RegNumBytes = NumRegs * StrbWidth;

  // Per-register write permission
  localparam strb_t ReadOnlyReg  = '1;
  localparam strb_t ReadWriteReg = '0;

  // Reset word for every register, placed by its byte offset
  function automatic logic [NumRegs-1:0][DataWidth-1:0] buildRstVal();
    logic [NumRegs-1:0][DataWidth-1:0] val;
    val = '0;
    val[TcdmStartOffset / StrbWidth] = TcdmBaseAddr;
    val[TcdmEndOffset / StrbWidth]   = TcdmBaseAddr + TcdmSize;
    val[NumCoresOffset / StrbWidth]  = NumCores;
    // Nothing has finished yet
    val[EocOffset / StrbWidth]       = '0;
    return val;
  endfunction

  // Byte mask, the three configuration words are fixed
  function automatic logic [NumRegs-1:0][StrbWidth-1:0] buildReadOnly();
    logic [NumRegs-1:0][StrbWidth-1:0] mask;
    mask = '0;
    mask[TcdmStartOffset / StrbWidth] = ReadOnlyReg;
    mask[TcdmEndOffset / StrbWidth]   = ReadOnlyReg;
    mask[NumCoresOffset / StrbWidth]  = ReadOnlyReg;
    mask[EocOffset / StrbWidth]       = ReadWriteReg;
    return mask;
  endfunction

  localparam logic [NumRegs-1:0][DataWidth-1:0] RegRstVal   = buildRstVal();
  localparam logic [NumRegs-1:0][StrbWidth-1:0] AxiReadOnly = buildReadOnly();

  // Flat register file contents, one word per register
  data_t [NumRegs-1:0] regQ;

  axiLiteRegs #(
    .RegNumBytes (RegNumBytes),
    .AxiReadOnly (AxiReadOnly),
    .RegRstVal   (RegRstVal  )
  ) iAxiLiteRegs (
    .clk_i     (clk_i    ),
    .rstN_i    (rstN_i   ),
    .axiReq_i  (axiReq_i ),
    .axiResp_o (axiResp_o),
    .regQ_o    (regQ     )
  );

  // Split the words out to the named level outputs
  assign tcdmStartAddr_o = regQ[TcdmStartOffset / StrbWidth];
  assign tcdmEndAddr_o   = regQ[TcdmEndOffset / StrbWidth];
  assign numCores_o      = regQ[NumCoresOffset / StrbWidth];
  assign eoc_o           = regQ[EocOffset / StrbWidth];

endmodule

`default_nettype wire

/* mempoolCtrl.sv */
`timescale 1ns/1ps
`default_nettype none

module mempoolCtrl import mempoolPkg::*; #(
  // Cluster configuration, fixed at elaboration
  parameter data_t TcdmBaseAddr = 32'h0010_0000,
  parameter data_t TcdmSize     = 32'h0004_0000,
  parameter data_t NumCores     = 32'd256
) (
  input  wire logic         clk_i,
  input  wire logic         rstN_i,
  // AXI-Lite slave port
  input  wire axiLiteReq_t  axiReq_i,
  output axiLiteResp_t      axiResp_o,
  // Register contents as levels
  output data_t             tcdmStartAddr_o,
  output data_t             tcdmEndAddr_o,
  output data_t             numCores_o,
  output data_t             eoc_o,
  // Address check port
  input  wire logic         checkReq_i,
  input  wire addr_t        checkAddr_i,
  output logic              checkValid_o,
  output logic              inTcdm_o
);

  // Range bounds shared between the outputs and the checker
  data_t tcdmStartAddr;
  data_t tcdmEndAddr;

  ctrlRegisters #(
    .TcdmBaseAddr (TcdmBaseAddr),
    .TcdmSize     (TcdmSize    ),
    .NumCores     (NumCores    )
  ) iCtrlRegisters (
    .clk_i           (clk_i        ),
    .rstN_i          (rstN_i       ),
    .axiReq_i        (axiReq_i     ),
    .axiResp_o       (axiResp_o    ),
    .tcdmStartAddr_o (tcdmStartAddr),
    .tcdmEndAddr_o   (tcdmEndAddr  ),
    .numCores_o      (numCores_o   ),
    .eoc_o           (eoc_o        )
  );

  tcdmAddrCheck iTcdmAddrCheck (
    .clk_i           (clk_i        ),
    .rstN_i          (rstN_i       ),
    .checkReq_i      (checkReq_i   ),
    .checkAddr_i     (checkAddr_i  ),
    .tcdmStartAddr_i (tcdmStartAddr),
    .tcdmEndAddr_i   (tcdmEndAddr  ),
    .checkValid_o    (checkValid_o ),
    .inTcdm_o        (inTcdm_o     )
  );

  assign tcdmStartAddr_o = tcdmStartAddr;
  assign tcdmEndAddr_o   = tcdmEndAddr;

endmodule

`default_nettype wire

/* mempoolPkg.sv */
`default_nettype none

package mempoolPkg;

  // Bus and register widths
  localparam int unsigned DataWidth = 32;
  localparam int unsigned AddrWidth = 32;
  // Bytes per data word, also the strobe width
  localparam int unsigned StrbWidth = DataWidth / 8;
  // Number of 32-bit control registers
  localparam int unsigned NumRegs   = 4;

  typedef logic [DataWidth-1:0] data_t;
  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [StrbWidth-1:0] strb_t;
  typedef logic [1:0]           axiResp_t;

  // AXI response codes
  localparam axiResp_t RespOkay   = 2'b00;
  localparam axiResp_t RespSlvErr = 2'b10;

  // Register map, byte offsets
  localparam addr_t TcdmStartOffset = 32'h0000_0000;
  localparam addr_t TcdmEndOffset   = 32'h0000_0004;
  localparam addr_t NumCoresOffset  = 32'h0000_0008;
  localparam addr_t EocOffset       = 32'h0000_000C;

  // Master to slave
  typedef struct packed {
    addr_t awAddr;
    logic  awValid;
    data_t wData;
    strb_t wStrb;
    logic  wValid;
    logic  bReady;
    addr_t arAddr;
    logic  arValid;
    logic  rReady;
  } axiLiteReq_t;

  // Slave to master
  typedef struct packed {
    logic     awReady;
    logic     wReady;
    axiResp_t bResp;
    logic     bValid;
    logic     arReady;
    data_t    rData;
    axiResp_t rResp;
    logic     rValid;
  } axiLiteResp_t;

endpackage

`default_nettype wire

/* tb.f */
mempoolPkg.sv
axiLiteRegs.sv
ctrlRegisters.sv
tcdmAddrCheck.sv
mempoolCtrl.sv
tbMempoolCtrl_properties.sv
tbMempoolCtrl.sv

/* tbMempoolCtrl.sv */
`timescale 1ns/1ps
`default_nettype none

module tbMempoolCtrl import mempoolPkg::*; ();

  localparam data_t       CfgTcdmBase = 32'h0010_0000;
  localparam data_t       CfgTcdmSize = 32'h0004_0000;
  localparam data_t       CfgNumCores = 32'd256;
  // Longest single wait in cycles
  localparam int unsigned WaitLimit   = 50;

  // Expected check result and the cycle it is due on
  typedef struct packed {
    logic [31:0] dueCycle;
    addr_t       addr;
    logic        inTcdm;
  } checkExp_t;

  logic         clk;
  logic         rstN;
  axiLiteReq_t  axiReq;
  axiLiteResp_t axiResp;
  data_t        tcdmStartAddr;
  data_t        tcdmEndAddr;
  data_t        numCores;
  data_t        eoc;
  logic         checkReq;
  addr_t        checkAddr;
  logic         checkValid;
  logic         inTcdm;

  data_t        modelRegs [NumRegs];
  checkExp_t    expChecks [$];
  data_t        lcgState    = 32'd98608;
  logic [31:0]  cycleCount  = '0;
  int unsigned  errCount    = 0;
  int unsigned  testErrs    = 0;
  int unsigned  testsRun    = 0;
  int unsigned  testsFailed = 0;

  mempoolCtrl #(
    .TcdmBaseAddr (CfgTcdmBase),
    .TcdmSize     (CfgTcdmSize),
    .NumCores     (CfgNumCores)
  ) uut (
    .clk_i           (clk          ),
    .rstN_i          (rstN         ),
    .axiReq_i        (axiReq       ),
    .axiResp_o       (axiResp      ),
    .tcdmStartAddr_o (tcdmStartAddr),
    .tcdmEndAddr_o   (tcdmEndAddr  ),
    .numCores_o      (numCores     ),
    .eoc_o           (eoc          ),
    .checkReq_i      (checkReq     ),
    .checkAddr_i     (checkAddr    ),
    .checkValid_o    (checkValid   ),
    .inTcdm_o        (inTcdm       )
  );

  // 20 ns period
  always #10 clk = ~clk;

  always @(posedge clk) cycleCount <= cycleCount + 1;

  function automatic data_t lcgNext();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState;
  endfunction

  // Register model that returns the expected response code
  function automatic axiResp_t refModel(input logic isWrite, input addr_t addr,
                                        input data_t wData, input strb_t wStrb,
                                        output data_t rData);
    addr_t idx;
    idx   = addr >> 2;
    rData = '0;
    if (idx >= NumRegs) return RespSlvErr;
    if (!isWrite) begin
      rData = modelRegs[idx];
      return RespOkay;
    end
    // Only eoc takes writes and any strobe elsewhere is refused
    if ((idx << 2) != EocOffset && wStrb != '0) return RespSlvErr;
    for (int b = 0; b < 4; b++) begin
      if (wStrb[b]) modelRegs[idx][8*b +: 8] = wData[8*b +: 8];
    end
    return RespOkay;
  endfunction

  // Half-open TCDM window
  function automatic logic refInTcdm(input addr_t addr);
    return (addr >= CfgTcdmBase) && (addr < CfgTcdmBase + CfgTcdmSize);
  endfunction

  task automatic noteError();
    errCount++;
    testErrs++;
  endtask

  task automatic reportTimeout(input string what);
    $display("Timed out at %0t waiting for %s", $time, what);
    noteError();
  endtask

  task automatic checkValue(input string name, input data_t expVal, input data_t actVal);
    assert (expVal === actVal) else begin
      $display("Mismatch at %0t: %s expected 0x%08h, got 0x%08h", $time, name, expVal, actVal);
      noteError();
    end
  endtask

  task automatic finishTest(input string name);
    testsRun++;
    if (testErrs == 0) begin
      $display("PASS  %s", name);
    end else begin
      $display("FAIL  %s, %0d errors", name, testErrs);
      testsFailed++;
    end
    testErrs = 0;
  endtask

  // Starts and ends 1 ns after a rising edge
  task automatic axiWrite(input addr_t addr, input data_t data, input strb_t strb,
                          input int unsigned stall, output axiResp_t resp);
    int unsigned waitCnt;
    axiReq.awAddr  = addr;
    axiReq.wData   = data;
    axiReq.wStrb   = strb;
    axiReq.awValid = 1'b1;
    axiReq.wValid  = 1'b1;
    axiReq.bReady  = (stall == 0);
    waitCnt = 0;
    @(negedge clk);
    while (!(axiResp.awReady && axiResp.wReady) && waitCnt < WaitLimit) begin
      @(negedge clk);
      waitCnt++;
    end
    if (!(axiResp.awReady && axiResp.wReady)) reportTimeout("awReady and wReady");
    @(posedge clk);
    #1;
    axiReq.awValid = 1'b0;
    axiReq.wValid  = 1'b0;
    waitCnt = 0;
    @(negedge clk);
    while (!axiResp.bValid && waitCnt < WaitLimit) begin
      @(negedge clk);
      waitCnt++;
    end
    if (!axiResp.bValid) reportTimeout("bValid");
    resp = axiResp.bResp;
    // Offer the same write again while bReady is low and expect it to stay untaken
    for (int i = 0; i < stall; i++) begin
      @(posedge clk);
      #1;
      axiReq.awValid = 1'b1;
      axiReq.wValid  = 1'b1;
      @(negedge clk);
      checkValue("bValid", 1, axiResp.bValid);
      checkValue("bResp", resp, axiResp.bResp);
      checkValue("awReady", 0, axiResp.awReady);
      checkValue("wReady", 0, axiResp.wReady);
    end
    if (stall != 0) begin
      @(posedge clk);
      #1;
      axiReq.awValid = 1'b0;
      axiReq.wValid  = 1'b0;
      axiReq.bReady  = 1'b1;
    end
    @(posedge clk);
    #1;
    axiReq.bReady = 1'b0;
  endtask

  task automatic axiRead(input addr_t addr, input int unsigned stall,
                         output data_t data, output axiResp_t resp);
    int unsigned waitCnt;
    axiReq.arAddr  = addr;
    axiReq.arValid = 1'b1;
    axiReq.rReady  = (stall == 0);
    waitCnt = 0;
    @(negedge clk);
    while (!axiResp.arReady && waitCnt < WaitLimit) begin
      @(negedge clk);
      waitCnt++;
    end
    if (!axiResp.arReady) reportTimeout("arReady");
    @(posedge clk);
    #1;
    axiReq.arValid = 1'b0;
    waitCnt = 0;
    @(negedge clk);
    while (!axiResp.rValid && waitCnt < WaitLimit) begin
      @(negedge clk);
      waitCnt++;
    end
    if (!axiResp.rValid) reportTimeout("rValid");
    data = axiResp.rData;
    resp = axiResp.rResp;
    // Second read offered under back-pressure stays unaccepted
    for (int i = 0; i < stall; i++) begin
      @(posedge clk);
      #1;
      axiReq.arValid = 1'b1;
      @(negedge clk);
      checkValue("rValid", 1, axiResp.rValid);
      checkValue("rData", data, axiResp.rData);
      checkValue("rResp", resp, axiResp.rResp);
      checkValue("arReady", 0, axiResp.arReady);
    end
    if (stall != 0) begin
      @(posedge clk);
      #1;
      axiReq.arValid = 1'b0;
      axiReq.rReady  = 1'b1;
    end
    @(posedge clk);
    #1;
    axiReq.rReady = 1'b0;
  endtask

  task automatic checkLevels();
    checkValue("tcdmStartAddr_o", modelRegs[TcdmStartOffset >> 2], tcdmStartAddr);
    checkValue("tcdmEndAddr_o", modelRegs[TcdmEndOffset >> 2], tcdmEndAddr);
    checkValue("numCores_o", modelRegs[NumCoresOffset >> 2], numCores);
    checkValue("eoc_o", modelRegs[EocOffset >> 2], eoc);
  endtask

  // One bus transfer against the model and then the level outputs
  task automatic checkedAccess(input logic isWrite, input addr_t addr, input data_t data,
                               input strb_t strb, input int unsigned stall);
    data_t    expData;
    data_t    actData;
    axiResp_t expResp;
    axiResp_t actResp;
    expResp = refModel(isWrite, addr, data, strb, expData);
    if (isWrite) begin
      axiWrite(addr, data, strb, stall, actResp);
      checkValue("bResp", expResp, actResp);
    end else begin
      axiRead(addr, stall, actData, actResp);
      checkValue("rResp", expResp, actResp);
      checkValue("rData", expData, actData);
    end
    checkLevels();
  endtask

  // Strobe must land exactly on the due cycle and the result must match
  always @(negedge clk) begin : compareChecks
    checkExp_t head;
    logic      due;
    due = (expChecks.size() != 0) && (expChecks[0].dueCycle == cycleCount);
    if (rstN) begin
      assert (checkValid === due) else begin
        $display("Mismatch at %0t: checkValid_o expected %0b, got %0b", $time, due, checkValid);
        noteError();
      end
      if (due) begin
        head = expChecks.pop_front();
        assert (inTcdm === head.inTcdm) else begin
          $display("Mismatch at %0t: inTcdm_o for 0x%08h expected %0b, got %0b",
                   $time, head.addr, head.inTcdm, inTcdm);
          noteError();
        end
      end
    end
  end

  initial begin
    data_t       rnd;
    addr_t       checkAddrs [$];
    int unsigned waitCnt;
    clk       = 1'b0;
    rstN      = 1'b0;
    axiReq    = '0;
    checkReq  = 1'b0;
    checkAddr = '0;
    modelRegs[TcdmStartOffset >> 2] = CfgTcdmBase;
    modelRegs[TcdmEndOffset >> 2]   = CfgTcdmBase + CfgTcdmSize;
    modelRegs[NumCoresOffset >> 2]  = CfgNumCores;
    modelRegs[EocOffset >> 2]       = '0;
    repeat (5) @(posedge clk);
    #1;
    rstN = 1'b1;

    for (int i = 0; i < NumRegs; i++) checkedAccess(1'b0, addr_t'(4 * i), '0, '0, 0);
    finishTest("reset values");

    // Low address bits vary too and must not matter
    for (int i = 0; i < 8; i++) begin
      rnd = lcgNext();
      checkedAccess(1'b1, EocOffset | addr_t'(i % 4), lcgNext(), rnd[23:20], 0);
      checkedAccess(1'b0, EocOffset, '0, '0, 0);
    end
    finishTest("eoc strobed writes");

    for (int i = 0; i < 3; i++) begin
      checkedAccess(1'b1, addr_t'(4 * i), lcgNext(), 4'hF, 0);
      checkedAccess(1'b0, addr_t'(4 * i), '0, '0, 0);
    end
    // Partial strobes still touch read-only bytes
    checkedAccess(1'b1, TcdmEndOffset, lcgNext(), 4'b0100, 0);
    checkedAccess(1'b1, NumCoresOffset, lcgNext(), 4'b0001, 0);
    checkedAccess(1'b0, TcdmEndOffset, '0, '0, 0);
    checkedAccess(1'b0, NumCoresOffset, '0, '0, 0);
    finishTest("read-only registers");

    checkAddrs = {32'h10, 32'h14, 32'hFFFF_FFFC};
    for (int i = 0; i < 3; i++) checkAddrs.push_back(32'h10 + (lcgNext() >> 8));
    foreach (checkAddrs[i]) begin
      checkedAccess(1'b1, checkAddrs[i], lcgNext(), 4'hF, 0);
      checkedAccess(1'b0, checkAddrs[i], '0, '0, 0);
    end
    finishTest("out of range");

    for (int i = 0; i < 6; i++) begin
      rnd = lcgNext();
      checkedAccess(1'b1, EocOffset, lcgNext(), 4'hF, 1 + (rnd >> 24) % 7);
      checkedAccess(1'b0, EocOffset, '0, '0, 1 + (rnd >> 16) % 7);
    end
    checkedAccess(1'b0, 32'h20, '0, '0, 3);
    finishTest("back-pressure");

    // Boundaries first and then random addresses with one request per cycle
    checkAddrs = {CfgTcdmBase, CfgTcdmBase - 1, CfgTcdmBase + CfgTcdmSize,
                  CfgTcdmBase + CfgTcdmSize - 1};
    for (int i = 0; i < 12; i++) begin
      rnd = lcgNext();
      checkAddrs.push_back(rnd[0] ? rnd : CfgTcdmBase - 32'h2_0000 + (rnd >> 12));
    end
    foreach (checkAddrs[i]) begin
      checkReq  = 1'b1;
      checkAddr = checkAddrs[i];
      expChecks.push_back('{dueCycle: cycleCount + 1, addr: checkAddrs[i],
                            inTcdm: refInTcdm(checkAddrs[i])});
      @(posedge clk);
      #1;
    end
    checkReq = 1'b0;
    waitCnt  = 0;
    while (expChecks.size() != 0 && waitCnt < WaitLimit) begin
      @(posedge clk);
      #1;
      waitCnt++;
    end
    if (expChecks.size() != 0) reportTimeout("all address check results");
    finishTest("address checks");

    errCount += uut.iProperties.failCount;
    $display("Summary: %0d tests run, %0d failed, %0d errors", testsRun, testsFailed, errCount);
    if (errCount == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tbMempoolCtrl_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module mempoolCtrlProperties import mempoolPkg::*; (
  input wire logic         clk_i,
  input wire logic         rstN_i,
  input wire axiLiteReq_t  axiReq_i,
  input wire axiLiteResp_t axiResp_i,
  input wire logic         checkValid_i,
  input wire logic         inTcdm_i
);

  // Running count of failures, summed into the testbench totals
  int unsigned failCount = 0;

  // Valids clear on the first reset edge and stay low while reset lasts
  noValidInReset: assert property (
    @(posedge clk_i) !rstN_i |=> !axiResp_i.bValid && !axiResp_i.rValid && !checkValid_i
  ) else begin
    $error("A valid output was high during reset");
    failCount++;
  end

  // Write response held, code frozen, until bReady
  bHeldUntilReady: assert property (
    @(posedge clk_i) disable iff (!rstN_i)
    axiResp_i.bValid && !axiReq_i.bReady |=> axiResp_i.bValid && $stable(axiResp_i.bResp)
  ) else begin
    $error("B response dropped or changed before bReady");
    failCount++;
  end

  // Read response held with stable payload until rReady
  rHeldUntilReady: assert property (
    @(posedge clk_i) disable iff (!rstN_i)
    axiResp_i.rValid && !axiReq_i.rReady |=>
      axiResp_i.rValid && $stable(axiResp_i.rData) && $stable(axiResp_i.rResp)
  ) else begin
    $error("R response dropped or changed before rReady");
    failCount++;
  end

  // The check result only counts alongside its strobe
  resultKnownWhenValid: assert property (
    @(posedge clk_i) disable iff (!rstN_i) checkValid_i |-> !$isunknown(inTcdm_i)
  ) else begin
    $error("inTcdm_o is unknown while checkValid_o is high");
    failCount++;
  end

endmodule

bind mempoolCtrl mempoolCtrlProperties iProperties (
  .clk_i        (clk_i       ),
  .rstN_i       (rstN_i      ),
  .axiReq_i     (axiReq_i    ),
  .axiResp_i    (axiResp_o   ),
  .checkValid_i (checkValid_o),
  .inTcdm_i     (inTcdm_o    )
);

`default_nettype wire

/* tcdmAddrCheck.sv */
`timescale 1ns/1ps
`default_nettype none

module tcdmAddrCheck import mempoolPkg::*; (
  input  wire logic   clk_i,
  input  wire logic   rstN_i,
  // Request strobe and the core address to classify
  input  wire logic   checkReq_i,
  input  wire addr_t  checkAddr_i,
  // Range bounds, end is exclusive
  input  wire data_t  tcdmStartAddr_i,
  input  wire data_t  tcdmEndAddr_i,
  output logic        checkValid_o,
  output logic        inTcdm_o
);

  logic aboveStart;
  logic belowEnd;
  logic checkValidQ;
  logic inTcdmQ;

  // Half-open interval [start, end)
  assign aboveStart = checkAddr_i >= tcdmStartAddr_i;
  assign belowEnd   = checkAddr_i <  tcdmEndAddr_i;

  // Result strobe follows the request by one cycle
  always_ff @(posedge clk_i) begin
    if (!rstN_i) begin
      checkValidQ <= 1'b0;
    end else begin
      checkValidQ <= checkReq_i;
    end
  end

  // Result only moves on a request, so it lines up with its strobe
  always_ff @(posedge clk_i) begin
    if (checkReq_i) begin
      inTcdmQ <= aboveStart & belowEnd;
    end
  end

  assign checkValid_o = checkValidQ;
  assign inTcdm_o     = inTcdmQ;

endmodule

`default_nettype wire
